// File: rtl/cpu_pkg.sv
package cpu_pkg;

    // ********************************************************************
    // widths
    // ********************************************************************

    typedef logic [15:0] word_t;
    typedef logic [15:0] inst_t;
    typedef logic [15:0] pc_t;
    typedef logic [2:0]  reg_addr_t;

    localparam int APB_ADDR_W = 12;
    localparam logic [APB_ADDR_W-1:0] RUN_REG_ADDR = 12'h400;

    // ********************************************************************
    // instruction encodings
    // ********************************************************************

    // major opcode, inst[15:11]
    typedef enum logic [4:0] {
        OP_NOP   = 5'b00001,
        OP_B     = 5'b00010,
        OP_BEQZ  = 5'b00100,
        OP_ADDIU = 5'b01001,
        OP_LI    = 5'b01101,
        OP_RRR   = 5'b11100,
        OP_LOGIC = 5'b11101
    } opcode_e;

    // rrr function, inst[1:0]
    localparam logic [1:0] FUNC_ADDU = 2'b01;
    localparam logic [1:0] FUNC_SUBU = 2'b11;
    // logic function, inst[4:0]
    localparam logic [4:0] FUNC_AND  = 5'b01100;
    localparam logic [4:0] FUNC_OR   = 5'b01101;

    localparam inst_t NOP_INST = 16'h0800;

    typedef enum logic [2:0] {
        ALU_PASS_B = 3'd0,
        ALU_ADD    = 3'd1,
        ALU_SUB    = 3'd2,
        ALU_AND    = 3'd3,
        ALU_OR     = 3'd4
    } alu_op_e;

    // ********************************************************************
    // pipeline buses
    // ********************************************************************

    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        logic    reg_write;
        logic    is_beqz;
        logic    is_b;
    } ex_ctrl_t;

    typedef struct packed {
        logic      valid;
        ex_ctrl_t  ctrl;
        reg_addr_t rx_addr;
        reg_addr_t ry_addr;
        reg_addr_t wb_addr;
        word_t     rx_data;
        word_t     ry_data;
        word_t     imm;
        pc_t       pc_next;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        word_t     data;
    } wb_trace_t;

endpackage

// File: rtl/apb_program_port.sv
`timescale 1ns/10ps

module apb_program_port #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                           clk_50MHz,
    input  logic                           rst,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [cpu_pkg::APB_ADDR_W-1:0] paddr,
    input  cpu_pkg::word_t                 pwdata,
    output cpu_pkg::word_t                 prdata,
    output logic                           pready,
    output logic                           pslverr,
    input  cpu_pkg::pc_t                   pc,
    output cpu_pkg::inst_t                 inst,
    output logic                           run
);

    import cpu_pkg::*;

    localparam int IDX_W = $clog2(IMEM_DEPTH);

    inst_t imem [IMEM_DEPTH];

    logic access;
    logic imem_hit;
    logic run_hit;
    logic imem_wr;
    logic run_wr;

    assign access   = psel && penable;
    assign imem_hit = paddr < IMEM_DEPTH;
    assign run_hit  = paddr == RUN_REG_ADDR;

    // program memory is locked while the core runs
    assign imem_wr = access && pwrite && imem_hit && !run;
    assign run_wr  = access && pwrite && run_hit;

    // zero wait states
    assign pready  = 1'b1;
    assign pslverr = access && (!(imem_hit || run_hit) || (imem_hit && pwrite && run));

    always_comb begin
        prdata = '0;
        if (imem_hit) begin
            prdata = imem[paddr[IDX_W-1:0]];
        end else if (run_hit) begin
            prdata = {15'd0, run};
        end
    end

    // instruction port, nop past the end of memory
    always_comb begin
        if (pc < IMEM_DEPTH) begin
            inst = imem[pc[IDX_W-1:0]];
        end else begin
            inst = NOP_INST;
        end
    end

    always_ff @(posedge clk_50MHz) begin
        if (imem_wr) begin
            imem[paddr[IDX_W-1:0]] <= pwdata;
        end
    end

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            run <= 1'b0;
        end else if (run_wr) begin
            run <= pwdata[0];
        end
    end

endmodule

// File: rtl/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic           clk_50MHz,
    input  logic           rst,
    input  logic           run,
    input  cpu_pkg::inst_t inst,
    input  logic           redirect,
    input  cpu_pkg::pc_t   redirect_pc,
    output cpu_pkg::pc_t   pc,
    output cpu_pkg::inst_t if_inst,
    output cpu_pkg::pc_t   if_pc_next,
    output logic           if_valid
);

    import cpu_pkg::*;

    pc_t  pc_q;
    pc_t  pc_inc;
    logic run_q;
    logic run_rise;
    logic in_range;

    // first cycle of a run always starts at address 0
    assign run_rise = run && !run_q;
    assign pc       = run_rise ? '0 : pc_q;
    assign pc_inc   = pc + 16'd1;
    assign in_range = pc < pc_t'(IMEM_DEPTH);

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            pc_q     <= '0;
            run_q    <= 1'b0;
            if_valid <= 1'b0;
        end else begin
            run_q <= run;
            // pc holds while stopped
            if (run) begin
                pc_q <= redirect ? redirect_pc : pc_inc;
            end
            if_valid <= run && in_range && !redirect;
        end
    end

    // fetch/decode register, bubbles carry a nop
    always_ff @(posedge clk_50MHz) begin
        if_inst    <= (run && !redirect) ? inst : NOP_INST;
        if_pc_next <= pc_inc;
    end

endmodule

// File: rtl/register_file.sv
`timescale 1ns/10ps

module register_file (
    input  logic               clk_50MHz,
    input  logic               rst,
    input  cpu_pkg::reg_addr_t rx_addr,
    input  cpu_pkg::reg_addr_t ry_addr,
    output cpu_pkg::word_t     rx_data,
    output cpu_pkg::word_t     ry_data,
    input  cpu_pkg::wb_trace_t wb
);

    import cpu_pkg::*;

    word_t regs [8];

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // same-cycle write passes straight through
    assign rx_data = (wb.valid && wb.addr == rx_addr) ? wb.data : regs[rx_addr];
    assign ry_data = (wb.valid && wb.addr == ry_addr) ? wb.data : regs[ry_addr];

endmodule

// File: rtl/decoder.sv
`timescale 1ns/10ps

module decoder (
    input  logic               clk_50MHz,
    input  logic               rst,
    input  cpu_pkg::inst_t     if_inst,
    input  cpu_pkg::pc_t       if_pc_next,
    input  logic               if_valid,
    input  logic               redirect,
    input  cpu_pkg::wb_trace_t wb,
    output cpu_pkg::id_ex_t    id_ex
);

    import cpu_pkg::*;

    opcode_e   opcode;
    reg_addr_t rx_addr;
    reg_addr_t ry_addr;
    reg_addr_t rz_addr;
    word_t     rx_data;
    word_t     ry_data;
    ex_ctrl_t  ctrl;
    reg_addr_t wb_addr;
    word_t     imm;

    assign opcode  = opcode_e'(if_inst[15:11]);
    assign rx_addr = if_inst[10:8];
    assign ry_addr = if_inst[7:5];
    assign rz_addr = if_inst[4:2];

    register_file u_register_file (
        .clk_50MHz (clk_50MHz),
        .rst       (rst),
        .rx_addr   (rx_addr),
        .ry_addr   (ry_addr),
        .rx_data   (rx_data),
        .ry_data   (ry_data),
        .wb        (wb)
    );

    always_comb begin
        ctrl.alu_op    = ALU_PASS_B;
        ctrl.use_imm   = 1'b0;
        ctrl.reg_write = 1'b0;
        ctrl.is_beqz   = 1'b0;
        ctrl.is_b      = 1'b0;
        wb_addr        = rx_addr;
        imm            = '0;
        case (opcode)
            OP_LI: begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = {8'h00, if_inst[7:0]};
            end
            OP_ADDIU: begin
                ctrl.alu_op    = ALU_ADD;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = {{8{if_inst[7]}}, if_inst[7:0]};
            end
            OP_RRR: begin
                wb_addr        = rz_addr;
                ctrl.alu_op    = (if_inst[1:0] == FUNC_SUBU) ? ALU_SUB : ALU_ADD;
                ctrl.reg_write = (if_inst[1:0] == FUNC_ADDU) || (if_inst[1:0] == FUNC_SUBU);
            end
            OP_LOGIC: begin
                ctrl.alu_op    = (if_inst[4:0] == FUNC_OR) ? ALU_OR : ALU_AND;
                ctrl.reg_write = (if_inst[4:0] == FUNC_AND) || (if_inst[4:0] == FUNC_OR);
            end
            OP_BEQZ: begin
                ctrl.is_beqz = 1'b1;
                imm          = {{8{if_inst[7]}}, if_inst[7:0]};
            end
            OP_B: begin
                ctrl.is_b = 1'b1;
                imm       = {{5{if_inst[10]}}, if_inst[10:0]};
            end
            // nop and unknown opcodes do nothing
            default: begin
            end
        endcase
    end

    // decode/execute register
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            id_ex <= '0;
        end else begin
            id_ex.valid   <= if_valid && !redirect;
            id_ex.ctrl    <= ctrl;
            id_ex.rx_addr <= rx_addr;
            id_ex.ry_addr <= ry_addr;
            id_ex.wb_addr <= wb_addr;
            id_ex.rx_data <= rx_data;
            id_ex.ry_data <= ry_data;
            id_ex.imm     <= imm;
            id_ex.pc_next <= if_pc_next;
        end
    end

endmodule

// File: rtl/execute_unit.sv
`timescale 1ns/10ps

module execute_unit (
    input  logic               clk_50MHz,
    input  logic               rst,
    input  cpu_pkg::id_ex_t    id_ex,
    output logic               redirect,
    output cpu_pkg::pc_t       redirect_pc,
    output cpu_pkg::wb_trace_t wb
);

    import cpu_pkg::*;

    word_t op_a;
    word_t ry_val;
    word_t op_b;
    word_t alu_y;
    logic  rx_zero;
    logic  take_branch;

    // ********************************************************************
    // operands
    // ********************************************************************

    // bypass from the writeback register
    assign op_a   = (wb.valid && wb.addr == id_ex.rx_addr) ? wb.data : id_ex.rx_data;
    assign ry_val = (wb.valid && wb.addr == id_ex.ry_addr) ? wb.data : id_ex.ry_data;

    assign op_b = id_ex.ctrl.use_imm ? id_ex.imm : ry_val;

    // ********************************************************************
    // alu
    // ********************************************************************

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_PASS_B: alu_y = op_b;
            ALU_ADD:    alu_y = op_a + op_b;
            ALU_SUB:    alu_y = op_a - op_b;
            ALU_AND:    alu_y = op_a & op_b;
            ALU_OR:     alu_y = op_a | op_b;
            default:    alu_y = op_b;
        endcase
    end

    // ********************************************************************
    // branch
    // ********************************************************************

    assign rx_zero     = op_a == '0;
    assign take_branch = id_ex.ctrl.is_b || (id_ex.ctrl.is_beqz && rx_zero);

    // target is relative to the next pc
    assign redirect    = id_ex.valid && take_branch;
    assign redirect_pc = id_ex.pc_next + id_ex.imm;

    // execute/writeback register
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            wb <= '0;
        end else begin
            wb.valid <= id_ex.valid && id_ex.ctrl.reg_write;
            wb.addr  <= id_ex.wb_addr;
            wb.data  <= alu_y;
        end
    end

endmodule

// File: rtl/cpu_top.sv
`timescale 1ns/10ps

module cpu_top #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                           clk_50MHz,
    input  logic                           rst,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [cpu_pkg::APB_ADDR_W-1:0] paddr,
    input  cpu_pkg::word_t                 pwdata,
    output cpu_pkg::word_t                 prdata,
    output logic                           pready,
    output logic                           pslverr,
    output cpu_pkg::wb_trace_t             retire
);

    import cpu_pkg::*;

    logic   run;
    pc_t    pc;
    inst_t  inst;
    inst_t  if_inst;
    pc_t    if_pc_next;
    logic   if_valid;
    logic   redirect;
    pc_t    redirect_pc;
    id_ex_t id_ex;

    // ********************************************************************
    // host port and fetch
    // ********************************************************************

    apb_program_port #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_apb_program_port (
        .clk_50MHz (clk_50MHz),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .pc        (pc),
        .inst      (inst),
        .run       (run)
    );

    fetch_unit #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_fetch_unit (
        .clk_50MHz   (clk_50MHz),
        .rst         (rst),
        .run         (run),
        .inst        (inst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc          (pc),
        .if_inst     (if_inst),
        .if_pc_next  (if_pc_next),
        .if_valid    (if_valid)
    );

    // ********************************************************************
    // decode, execute, writeback
    // ********************************************************************

    decoder u_decoder (
        .clk_50MHz  (clk_50MHz),
        .rst        (rst),
        .if_inst    (if_inst),
        .if_pc_next (if_pc_next),
        .if_valid   (if_valid),
        .redirect   (redirect),
        .wb         (retire),
        .id_ex      (id_ex)
    );

    // writeback bus doubles as the retire trace
    execute_unit u_execute_unit (
        .clk_50MHz   (clk_50MHz),
        .rst         (rst),
        .id_ex       (id_ex),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .wb          (retire)
    );

endmodule

// File: test/cpu_properties.sv
`timescale 1ns/10ps

module cpu_properties (
    input logic               clk_50MHz,
    input logic               rst,
    input logic               psel,
    input logic               penable,
    input logic               pslverr,
    input logic               run,
    input logic               redirect,
    input cpu_pkg::wb_trace_t wb
);

    logic        run_seen;
    int unsigned failures = 0;

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            run_seen <= 1'b0;
        end else if (run) begin
            run_seen <= 1'b1;
        end
    end

    // ********************************************************************
    // host port and execute unit
    // ********************************************************************

    // an access phase always follows exactly one setup cycle
    slverr_in_access: assert property (@(posedge clk_50MHz) disable iff (!rst)
        pslverr |-> (psel && penable && $past(psel && !penable)))
        else begin
            failures = failures + 1;
            $error("pslverr raised outside an APB access phase");
        end

    // branch itself and both flushed slots write nothing
    flush_after_redirect: assert property (@(posedge clk_50MHz) disable iff (!rst)
        redirect |=> !wb.valid ##1 !wb.valid ##1 !wb.valid)
        else begin
            failures = failures + 1;
            $error("register write retired within three cycles of a redirect");
        end

    quiet_before_run: assert property (@(posedge clk_50MHz) disable iff (!rst)
        !run_seen |-> !wb.valid)
        else begin
            failures = failures + 1;
            $error("register write retired before the run bit was ever set");
        end

endmodule

bind cpu_top cpu_properties u_cpu_properties (
    .clk_50MHz (clk_50MHz),
    .rst       (rst),
    .psel      (psel),
    .penable   (penable),
    .pslverr   (pslverr),
    .run       (run),
    .redirect  (redirect),
    .wb        (retire)
);

// File: test/cpu_tb.sv
`timescale 1ns/10ps

module cpu_tb;

    import cpu_pkg::*;

    localparam int IMEM_DEPTH     = 256;
    localparam int CLK_HALF       = 10;
    localparam int DRIVE_DELAY    = 2;
    localparam int APB_TIMEOUT    = 16;
    localparam int RETIRE_TIMEOUT = 32;
    localparam int IDLE_WINDOW    = 16;
    localparam int MAX_ENTRIES    = 32;
    localparam logic [APB_ADDR_W-1:0] UNMAPPED_ADDR = 12'h300;

    typedef struct packed {
        inst_t     inst;
        logic      retires;
        reg_addr_t rd;
        word_t     value;
    } entry_t;

    logic                  clk_50MHz;
    logic                  rst;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    word_t                 pwdata;
    word_t                 prdata;
    logic                  pready;
    logic                  pslverr;
    wb_trace_t             retire;

    entry_t      prog [MAX_ENTRIES];
    int          n_entries;
    int          skip_count;
    word_t       model_regs [8];

    cpu_top #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) dut (
        .clk_50MHz (clk_50MHz),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .retire    (retire)
    );

    initial begin
        clk_50MHz = 1'b0;
        forever begin
            #CLK_HALF clk_50MHz = ~clk_50MHz;
        end
    end

    // ********************************************************************
    // reporting and bus access
    // ********************************************************************

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input word_t got, input word_t expected);
        stop_with_error($sformatf("[ERROR] %0t %s got 0x%04h expected 0x%04h",
                                  $time, name, got, expected));
    endtask

    task automatic next_cycle();
        @(posedge clk_50MHz);
        #DRIVE_DELAY;
    endtask

    task automatic bus_transfer(
        input  logic                  write,
        input  logic [APB_ADDR_W-1:0] addr,
        input  word_t                 wdata,
        output word_t                 rdata,
        output logic                  error
    );
        int waited;
        next_cycle();
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        next_cycle();
        penable = 1'b1;
        waited  = 0;
        #1;
        while (!pready && waited < APB_TIMEOUT) begin
            next_cycle();
            #1;
            waited++;
        end
        assert (pready) else stop_with_error("APB transfer never saw pready");
        rdata = prdata;
        error = pslverr;
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_word(
        input logic [APB_ADDR_W-1:0] addr,
        input word_t                 data,
        input logic                  exp_err
    );
        word_t rdata;
        logic  err;
        bus_transfer(1'b1, addr, data, rdata, err);
        assert (err == exp_err) else report_mismatch("pslverr", {15'd0, err}, {15'd0, exp_err});
    endtask

    task automatic read_word(
        input logic [APB_ADDR_W-1:0] addr,
        input word_t                 exp_data,
        input logic                  exp_err
    );
        word_t rdata;
        logic  err;
        bus_transfer(1'b0, addr, 16'h0000, rdata, err);
        assert (err == exp_err) else report_mismatch("pslverr", {15'd0, err}, {15'd0, exp_err});
        if (!exp_err) begin
            assert (rdata == exp_data) else report_mismatch("prdata", rdata, exp_data);
        end
    endtask

    // ********************************************************************
    // program table with an ISA-level register model
    // ********************************************************************

    // entries inside a taken branch's shadow never retire
    task automatic store_entry(
        input  inst_t     inst,
        input  logic      writes,
        input  reg_addr_t rd,
        input  word_t     value,
        output logic      executed
    );
        executed = (skip_count == 0);
        if (!executed) begin
            skip_count--;
        end
        prog[n_entries].inst    = inst;
        prog[n_entries].retires = writes && executed;
        prog[n_entries].rd      = rd;
        prog[n_entries].value   = value;
        n_entries++;
        if (writes && executed) begin
            model_regs[rd] = value;
        end
    endtask

    task automatic add_write(input inst_t inst, input reg_addr_t rd, input word_t value);
        logic executed;
        store_entry(inst, 1'b1, rd, value, executed);
    endtask

    task automatic add_branch(input inst_t inst, input logic taken, input int offset);
        logic executed;
        store_entry(inst, 1'b0, 3'd0, 16'h0000, executed);
        if (executed && taken && offset > 0) begin
            skip_count = offset;
        end
    endtask

    task automatic build_program();
        logic [7:0] lit_a;
        logic [7:0] lit_b;
        lit_a = 8'($urandom_range(255, 0));
        // nonzero so the second beqz falls through
        lit_b = 8'($urandom_range(255, 1));
        add_write({5'b01101, 3'd2, lit_b}, 3'd2, {8'h00, lit_b});
        add_write({5'b01101, 3'd1, lit_a}, 3'd1, {8'h00, lit_a});
        add_write({5'b01001, 3'd1, 8'hf6}, 3'd1, model_regs[1] + 16'hfff6);
        add_write({5'b11100, 3'd1, 3'd2, 3'd3, 2'b01}, 3'd3, model_regs[1] + model_regs[2]);
        add_write({5'b11100, 3'd3, 3'd1, 3'd4, 2'b11}, 3'd4, model_regs[3] - model_regs[1]);
        add_write({5'b11101, 3'd4, 3'd3, 5'b01100}, 3'd4, model_regs[4] & model_regs[3]);
        add_write({5'b11101, 3'd4, 3'd2, 5'b01101}, 3'd4, model_regs[4] | model_regs[2]);
        add_write({5'b01101, 3'd5, 8'h00}, 3'd5, 16'h0000);
        add_branch({5'b00100, 3'd5, 8'h02}, model_regs[5] == 16'h0000, 2);
        add_write({5'b01101, 3'd6, 8'h11}, 3'd6, 16'h0011);
        add_write({5'b01101, 3'd6, 8'h22}, 3'd6, 16'h0022);
        add_branch({5'b00100, 3'd4, 8'h01}, model_regs[4] == 16'h0000, 1);
        add_write({5'b01101, 3'd6, 8'h5a}, 3'd6, 16'h005a);
        add_branch({5'b00010, 11'h002}, 1'b1, 2);
        add_write({5'b01101, 3'd7, 8'h77}, 3'd7, 16'h0077);
        add_write({5'b01001, 3'd6, 8'h01}, 3'd6, model_regs[6] + 16'h0001);
        add_write({5'b01001, 3'd6, 8'h7f}, 3'd6, model_regs[6] + 16'h007f);
        add_write({5'b11101, 3'd6, 3'd1, 5'b01101}, 3'd6, model_regs[6] | model_regs[1]);
        // parks the core on a branch to itself
        add_branch({5'b00010, 11'h7ff}, 1'b1, -1);
    endtask

    task automatic expect_retire(input entry_t e);
        int waited;
        waited = 0;
        @(negedge clk_50MHz);
        while (!retire.valid && waited < RETIRE_TIMEOUT) begin
            @(negedge clk_50MHz);
            waited++;
        end
        assert (retire.valid) else stop_with_error("timed out waiting for retire.valid");
        assert (retire.addr == e.rd)
            else report_mismatch("retire.addr", {13'd0, retire.addr}, {13'd0, e.rd});
        assert (retire.data == e.value) else report_mismatch("retire.data", retire.data, e.value);
    endtask

    task automatic check_quiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk_50MHz);
            assert (!retire.valid) else stop_with_error("register write retired after the end");
        end
    endtask

    task automatic run_and_check();
        write_word(RUN_REG_ADDR, 16'h0001, 1'b0);
        for (int i = 0; i < n_entries; i++) begin
            if (prog[i].retires) begin
                expect_retire(prog[i]);
            end
        end
        check_quiet(IDLE_WINDOW);
    endtask

    // ********************************************************************
    // main sequence
    // ********************************************************************

    initial begin
        rst        = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        n_entries  = 0;
        skip_count = 0;
        void'($urandom(95));
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = '0;
        end

        repeat (3) @(posedge clk_50MHz);
        #DRIVE_DELAY;
        rst = 1'b1;

        @(negedge clk_50MHz);
        assert (!retire.valid) else stop_with_error("retire.valid set right after reset");
        read_word(RUN_REG_ADDR, 16'h0000, 1'b0);

        build_program();
        for (int i = 0; i < n_entries; i++) begin
            write_word(APB_ADDR_W'(i), prog[i].inst, 1'b0);
        end
        for (int i = 0; i < n_entries; i++) begin
            read_word(APB_ADDR_W'(i), prog[i].inst, 1'b0);
        end
        read_word(UNMAPPED_ADDR, 16'h0000, 1'b1);
        write_word(UNMAPPED_ADDR, 16'hbeef, 1'b1);

        run_and_check();

        // memory is locked while running
        write_word(12'h000, 16'hffff, 1'b1);
        write_word(12'h005, 16'h1234, 1'b1);
        write_word(12'h7ff, 16'h0001, 1'b1);
        write_word(RUN_REG_ADDR, 16'h0000, 1'b0);
        read_word(RUN_REG_ADDR, 16'h0000, 1'b0);
        read_word(12'h000, prog[0].inst, 1'b0);
        read_word(12'h005, prog[5].inst, 1'b0);

        run_and_check();

        assert (dut.u_cpu_properties.failures == 0)
            else stop_with_error("a bound property check failed during the run");
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: compile.f
rtl/cpu_pkg.sv
rtl/apb_program_port.sv
rtl/fetch_unit.sv
rtl/register_file.sv
rtl/decoder.sv
rtl/execute_unit.sv
rtl/cpu_top.sv
test/cpu_properties.sv
test/cpu_tb.sv

// File: Bender.yml
package:
  name: cpu16

sources:
  - rtl/cpu_pkg.sv
  - rtl/apb_program_port.sv
  - rtl/fetch_unit.sv
  - rtl/register_file.sv
  - rtl/decoder.sv
  - rtl/execute_unit.sv
  - rtl/cpu_top.sv
  - target: test
    files:
      - test/cpu_properties.sv
      - test/cpu_tb.sv
